// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_int_exec
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
src/cpu_params_pkg.sv
src/prf_types_pkg.sv
src/rs_prf_if.sv
src/issue_select.sv
src/prf.sv
src/int_alu.sv
src/int_exec_top.sv
dv/tb_int_exec.sv

// File: dv/tb_int_exec.sv
`timescale 1ns/1ps

module tb_int_exec;

    logic                            clk;
    logic                            rst;
    logic                            issue_valid;
    prf_types_pkg::alu_op_e          issue_op;
    prf_types_pkg::phy_idx_t         issue_rs1_phy;
    prf_types_pkg::phy_idx_t         issue_rs2_phy;
    prf_types_pkg::phy_idx_t         issue_rd_phy;
    logic                            ext_wb_valid;
    prf_types_pkg::phy_idx_t         ext_wb_phy;
    logic [cpu_params_pkg::XLEN-1:0] ext_wb_value;
    logic                            alu_wb_valid;
    prf_types_pkg::phy_idx_t         alu_wb_phy;
    logic [cpu_params_pkg::XLEN-1:0] alu_wb_value;

    // register contents as seen by the instruction in the issue stage
    logic [cpu_params_pkg::XLEN-1:0] shadow [cpu_params_pkg::PRF_DEPTH];

    // held instruction, its predicted result one cycle on, then the expected writeback
    logic                            st_valid;
    prf_types_pkg::alu_op_e          st_op;
    prf_types_pkg::phy_idx_t         st_rs1;
    prf_types_pkg::phy_idx_t         st_rs2;
    prf_types_pkg::phy_idx_t         st_rd;
    logic                            res_valid;
    prf_types_pkg::phy_idx_t         res_phy;
    logic [cpu_params_pkg::XLEN-1:0] res_value;
    logic                            wb_valid_exp;
    prf_types_pkg::phy_idx_t         wb_phy_exp;
    logic [cpu_params_pkg::XLEN-1:0] wb_value_exp;
    integer                          seed;

    int_exec_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_rs1_phy (issue_rs1_phy),
        .issue_rs2_phy (issue_rs2_phy),
        .issue_rd_phy  (issue_rd_phy),
        .ext_wb_valid  (ext_wb_valid),
        .ext_wb_phy    (ext_wb_phy),
        .ext_wb_value  (ext_wb_value),
        .alu_wb_valid  (alu_wb_valid),
        .alu_wb_phy    (alu_wb_phy),
        .alu_wb_value  (alu_wb_value)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] predict_result(input prf_types_pkg::alu_op_e op,
                                                   input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (op)
            prf_types_pkg::ADD: r = a + b;
            prf_types_pkg::SUB: r = a - b;
            prf_types_pkg::AND: r = a & b;
            prf_types_pkg::OR:  r = a | b;
            prf_types_pkg::XOR: r = a ^ b;
            prf_types_pkg::SLL: r = a << b[4:0];
            prf_types_pkg::SRL: r = a >> b[4:0];
            default:            r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("*** TEST FAILED ***");
        $fatal(1, "writeback mismatch");
    endtask

    // one clock cycle that updates the model and then drives issue and lane 1 after the edge
    task automatic drive_cycle(input logic iv, input prf_types_pkg::alu_op_e op,
                               input prf_types_pkg::phy_idx_t rs1,
                               input prf_types_pkg::phy_idx_t rs2,
                               input prf_types_pkg::phy_idx_t rd, input logic ev,
                               input prf_types_pkg::phy_idx_t etag, input logic [31:0] evalue);
        prf_types_pkg::phy_idx_t tag;
        @(posedge clk);
        #10;
        tag = etag;
        wb_valid_exp = res_valid;
        wb_phy_exp   = res_phy;
        wb_value_exp = res_value;
        // lane 1 keeps off the nonzero tag that lane 0 carries now
        if (ev && wb_valid_exp && wb_phy_exp != '0 && tag == wb_phy_exp) begin
            tag = tag ^ 5'd1;
        end
        if (ev && tag != '0) begin
            shadow[tag] = evalue;
        end
        res_valid = st_valid;
        if (st_valid) begin
            res_phy   = st_rd;
            res_value = predict_result(st_op, shadow[st_rs1], shadow[st_rs2]);
            if (st_rd != '0) begin
                shadow[st_rd] = res_value;
            end
        end
        ext_wb_valid  = ev;
        ext_wb_phy    = tag;
        ext_wb_value  = evalue;
        issue_valid   = iv;
        issue_op      = op;
        issue_rs1_phy = rs1;
        issue_rs2_phy = rs2;
        issue_rd_phy  = rd;
        st_valid = iv;
        st_op    = op;
        st_rs1   = rs1;
        st_rs2   = rs2;
        st_rd    = rd;
    endtask

    task automatic issue_cycle(input prf_types_pkg::alu_op_e op,
                               input prf_types_pkg::phy_idx_t rs1,
                               input prf_types_pkg::phy_idx_t rs2,
                               input prf_types_pkg::phy_idx_t rd);
        drive_cycle(1'b1, op, rs1, rs2, rd, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic ext_write_cycle(input prf_types_pkg::phy_idx_t tag, input logic [31:0] value);
        drive_cycle(1'b0, prf_types_pkg::ADD, 5'd0, 5'd0, 5'd0, 1'b1, tag, value);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, prf_types_pkg::ADD, 5'd0, 5'd0, 5'd0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic wait_first_wb(input int limit);
        int n;
        n = 0;
        while (!alu_wb_valid && n < limit) begin
            idle_cycle();
            n++;
        end
        if (!alu_wb_valid) begin
            $display("no ALU writeback seen within %0d cycles of the first issue", limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "writeback timeout");
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while ((alu_wb_valid || st_valid || res_valid) && n < limit) begin
            idle_cycle();
            n++;
        end
        if (alu_wb_valid || st_valid || res_valid) begin
            $display("pipeline did not drain within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "drain timeout");
        end
    endtask

    wb_valid_match_a: assert property (@(posedge clk) disable iff (rst)
        alu_wb_valid == wb_valid_exp
    ) else report_mismatch("alu_wb_valid", {31'b0, $sampled(alu_wb_valid)},
                           {31'b0, $sampled(wb_valid_exp)});

    wb_phy_match_a: assert property (@(posedge clk) disable iff (rst)
        wb_valid_exp |-> alu_wb_phy == wb_phy_exp
    ) else report_mismatch("alu_wb_phy", {27'b0, $sampled(alu_wb_phy)},
                           {27'b0, $sampled(wb_phy_exp)});

    wb_value_match_a: assert property (@(posedge clk) disable iff (rst)
        wb_valid_exp |-> alu_wb_value == wb_value_exp
    ) else report_mismatch("alu_wb_value", $sampled(alu_wb_value), $sampled(wb_value_exp));

    initial begin
        logic [31:0]             r;
        logic [31:0]             v;
        prf_types_pkg::phy_idx_t last_rd;
        prf_types_pkg::phy_idx_t src1;
        prf_types_pkg::phy_idx_t src2;
        seed          = 32'hd91103d4;
        rst           = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = prf_types_pkg::ADD;
        issue_rs1_phy = '0;
        issue_rs2_phy = '0;
        issue_rd_phy  = '0;
        ext_wb_valid  = 1'b0;
        ext_wb_phy    = '0;
        ext_wb_value  = '0;
        st_valid      = 1'b0;
        res_valid     = 1'b0;
        wb_valid_exp  = 1'b0;
        last_rd       = 5'd1;
        for (int i = 0; i < cpu_params_pkg::PRF_DEPTH; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        // quiet after reset, then load every register through lane 1
        repeat (4) idle_cycle();
        for (int i = 1; i < cpu_params_pkg::PRF_DEPTH; i++) begin
            v = $random(seed);
            ext_write_cycle(i[4:0], v);
        end
        issue_cycle(prf_types_pkg::ADD, 5'd1, 5'd2, 5'd20);
        wait_first_wb(8);
        wait_idle(8);
        for (int i = 0; i < 8; i++) begin
            issue_cycle(prf_types_pkg::alu_op_e'(i[2:0]), 5'd1 + i[4:0], 5'd9 + i[4:0],
                        5'd17 + i[4:0]);
        end
        wait_idle(8);
        // dependent chain through the lane 0 bypass
        issue_cycle(prf_types_pkg::ADD, 5'd1, 5'd2, 5'd25);
        issue_cycle(prf_types_pkg::SUB, 5'd25, 5'd3, 5'd26);
        issue_cycle(prf_types_pkg::XOR, 5'd4, 5'd26, 5'd27);
        issue_cycle(prf_types_pkg::SLL, 5'd27, 5'd5, 5'd28);
        issue_cycle(prf_types_pkg::OR, 5'd28, 5'd27, 5'd29);
        issue_cycle(prf_types_pkg::SRL, 5'd29, 5'd6, 5'd30);
        issue_cycle(prf_types_pkg::SLT, 5'd30, 5'd7, 5'd31);
        issue_cycle(prf_types_pkg::AND, 5'd31, 5'd31, 5'd25);
        wait_idle(8);
        // lane 1 rewrites a source while the reader is in the stage
        issue_cycle(prf_types_pkg::ADD, 5'd8, 5'd9, 5'd20);
        ext_write_cycle(5'd8, 32'h1234_5678);
        issue_cycle(prf_types_pkg::SUB, 5'd10, 5'd11, 5'd21);
        ext_write_cycle(5'd11, 32'h0f0f_0f0f);
        wait_idle(8);
        // tag 0 reads zero whatever either lane writes to it
        issue_cycle(prf_types_pkg::ADD, 5'd0, 5'd0, 5'd12);
        issue_cycle(prf_types_pkg::OR, 5'd3, 5'd4, 5'd0);
        issue_cycle(prf_types_pkg::ADD, 5'd0, 5'd5, 5'd13);
        issue_cycle(prf_types_pkg::XOR, 5'd0, 5'd6, 5'd14);
        ext_write_cycle(5'd0, 32'hdead_beef);
        issue_cycle(prf_types_pkg::SUB, 5'd0, 5'd7, 5'd15);
        wait_idle(8);
        for (int n = 0; n < 300; n++) begin
            r    = $random(seed);
            v    = $random(seed);
            src1 = r[3] ? last_rd : r[8:4];
            src2 = r[9] ? last_rd : r[14:10];
            drive_cycle(r[0] | r[1], prf_types_pkg::alu_op_e'(r[22:20]), src1, src2, r[19:15],
                        r[23], r[28:24], v);
            if (r[0] | r[1]) begin
                last_rd = r[19:15];
            end
        end
        wait_idle(8);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: src/cpu_params_pkg.sv
package cpu_params_pkg;

    // integer datapath width
    localparam int XLEN = 32;

    // shift amount width taken from the low bits of source 2
    localparam int SHAMT_W = $clog2(XLEN);

    // physical register file sizing
    localparam int PRF_DEPTH = 32;
    localparam int PRF_IDX_W = $clog2(PRF_DEPTH);

    // lane 0 of the result bus carries the ALU and lane 1 the external writeback
    localparam int CDB_WIDTH = 2;
    localparam int ALU_LANE  = 0;
    localparam int EXT_LANE  = 1;

endpackage

// File: src/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  logic                    clk,
    input  logic                    rst,
    input  prf_types_pkg::alu_req_t alu_req,
    rs_prf_if.alu                   opnd,
    output prf_types_pkg::cdb_t     cdb_out
);

    logic [cpu_params_pkg::XLEN-1:0]    src1;
    logic [cpu_params_pkg::XLEN-1:0]    src2;
    logic [cpu_params_pkg::SHAMT_W-1:0] shamt;
    logic [cpu_params_pkg::XLEN-1:0]    result;

    logic                               out_valid;
    prf_types_pkg::phy_idx_t            out_phy;
    logic [cpu_params_pkg::XLEN-1:0]    out_value;

    assign src1  = opnd.rs1_value;
    assign src2  = opnd.rs2_value;
    assign shamt = src2[cpu_params_pkg::SHAMT_W-1:0];

    always_comb begin
        case (alu_req.op)
            prf_types_pkg::ADD: result = src1 + src2;
            prf_types_pkg::SUB: result = src1 - src2;
            prf_types_pkg::AND: result = src1 & src2;
            prf_types_pkg::OR:  result = src1 | src2;
            prf_types_pkg::XOR: result = src1 ^ src2;
            prf_types_pkg::SLL: result = src1 << shamt;
            prf_types_pkg::SRL: result = src1 >> shamt;
            // signed compare result in bit 0
            prf_types_pkg::SLT: result = {{(cpu_params_pkg::XLEN-1){1'b0}},
                                          ($signed(src1) < $signed(src2))};
            default:            result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= alu_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_req.valid) begin
            out_phy   <= alu_req.rd_phy;
            out_value <= result;
        end
    end

    assign cdb_out.valid    = out_valid;
    assign cdb_out.rd_phy   = out_phy;
    assign cdb_out.rd_value = out_value;

    // catches unwritten registers or a bad bypass anywhere upstream
    wb_value_known_a: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown({out_phy, out_value})
    ) else $error("int_alu: writeback valid with unknown tag or value");

endmodule

// File: src/int_exec_top.sv
`timescale 1ns/1ps

module int_exec_top (
    input  logic                            clk,
    input  logic                            rst,

    // renamed instruction
    input  logic                            issue_valid,
    input  prf_types_pkg::alu_op_e          issue_op,
    input  prf_types_pkg::phy_idx_t         issue_rs1_phy,
    input  prf_types_pkg::phy_idx_t         issue_rs2_phy,
    input  prf_types_pkg::phy_idx_t         issue_rd_phy,

    // external writeback driven onto CDB lane 1
    input  logic                            ext_wb_valid,
    input  prf_types_pkg::phy_idx_t         ext_wb_phy,
    input  logic [cpu_params_pkg::XLEN-1:0] ext_wb_value,

    // ALU result as seen on CDB lane 0
    output logic                            alu_wb_valid,
    output prf_types_pkg::phy_idx_t         alu_wb_phy,
    output logic [cpu_params_pkg::XLEN-1:0] alu_wb_value
);

    prf_types_pkg::cdb_t     cdb [cpu_params_pkg::CDB_WIDTH];
    prf_types_pkg::cdb_t     alu_lane;
    prf_types_pkg::alu_req_t alu_req;

    rs_prf_if rs_prf ();

    assign cdb[cpu_params_pkg::ALU_LANE] = alu_lane;
    assign cdb[cpu_params_pkg::EXT_LANE] = '{
        valid:    ext_wb_valid,
        rd_phy:   ext_wb_phy,
        rd_value: ext_wb_value
    };

    assign alu_wb_valid = alu_lane.valid;
    assign alu_wb_phy   = alu_lane.rd_phy;
    assign alu_wb_value = alu_lane.rd_value;

    issue_select issue_select_i (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_rs1_phy (issue_rs1_phy),
        .issue_rs2_phy (issue_rs2_phy),
        .issue_rd_phy  (issue_rd_phy),
        .cdb           (cdb),
        .rs            (rs_prf.rs),
        .alu_req       (alu_req)
    );

    prf prf_i (
        .clk (clk),
        .cdb (cdb),
        .rs  (rs_prf.prf)
    );

    int_alu int_alu_i (
        .clk     (clk),
        .rst     (rst),
        .alu_req (alu_req),
        .opnd    (rs_prf.alu),
        .cdb_out (alu_lane)
    );

endmodule

// File: src/issue_select.sv
`timescale 1ns/1ps

module issue_select (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  prf_types_pkg::alu_op_e  issue_op,
    input  prf_types_pkg::phy_idx_t issue_rs1_phy,
    input  prf_types_pkg::phy_idx_t issue_rs2_phy,
    input  prf_types_pkg::phy_idx_t issue_rd_phy,
    input  prf_types_pkg::cdb_t     cdb [cpu_params_pkg::CDB_WIDTH],
    rs_prf_if.rs                    rs,
    output prf_types_pkg::alu_req_t alu_req
);

    logic                    stage_valid;
    prf_types_pkg::alu_op_e  stage_op;
    prf_types_pkg::phy_idx_t stage_rs1;
    prf_types_pkg::phy_idx_t stage_rs2;
    prf_types_pkg::phy_idx_t stage_rd;
    prf_types_pkg::bypass_t  byp;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= issue_valid;
        end
    end

    // payload only moves when a new instruction arrives
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            stage_op  <= issue_op;
            stage_rs1 <= issue_rs1_phy;
            stage_rs2 <= issue_rs2_phy;
            stage_rd  <= issue_rd_phy;
        end
    end

    // lanes currently writing this tag where tag 0 never matches
    function automatic logic [cpu_params_pkg::CDB_WIDTH-1:0] lane_hits(
        input prf_types_pkg::phy_idx_t tag
    );
        logic [cpu_params_pkg::CDB_WIDTH-1:0] hits;
        hits = '0;
        for (int k = 0; k < cpu_params_pkg::CDB_WIDTH; k++) begin
            hits[k] = cdb[k].valid && (cdb[k].rd_phy != '0) && (cdb[k].rd_phy == tag);
        end
        return hits;
    endfunction

    always_comb begin
        byp.rs1_bypass_en = '0;
        byp.rs2_bypass_en = '0;
        if (stage_valid) begin
            byp.rs1_bypass_en = lane_hits(stage_rs1);
            byp.rs2_bypass_en = lane_hits(stage_rs2);
        end
    end

    assign rs.rs1_phy = stage_rs1;
    assign rs.rs2_phy = stage_rs2;
    assign rs.bypass  = byp;

    assign alu_req.valid  = stage_valid;
    assign alu_req.op     = stage_op;
    assign alu_req.rd_phy = stage_rd;

    // holds only while the two writeback sources never share a nonzero tag
    bypass_onehot_a: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(byp.rs1_bypass_en) && $onehot0(byp.rs2_bypass_en)
    ) else $error("issue_select: multi-hot bypass select");

endmodule

// File: src/prf.sv
`timescale 1ns/1ps

module prf (
    input  logic                clk,
    input  prf_types_pkg::cdb_t cdb [cpu_params_pkg::CDB_WIDTH],
    rs_prf_if.prf               rs
);

    // register 0 has no storage
    logic [cpu_params_pkg::XLEN-1:0]      regs [1:cpu_params_pkg::PRF_DEPTH-1];
    logic [cpu_params_pkg::CDB_WIDTH-1:0] lane_wr;
    logic                                 tag_clash;

    always_comb begin
        for (int k = 0; k < cpu_params_pkg::CDB_WIDTH; k++) begin
            lane_wr[k] = cdb[k].valid && (cdb[k].rd_phy != '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < cpu_params_pkg::CDB_WIDTH; k++) begin
            if (lane_wr[k]) begin
                regs[cdb[k].rd_phy] <= cdb[k].rd_value;
            end
        end
    end

    // array value, or the selected lane when the issue stage asked for it
    function automatic logic [cpu_params_pkg::XLEN-1:0] read_port(
        input prf_types_pkg::phy_idx_t              tag,
        input logic [cpu_params_pkg::CDB_WIDTH-1:0] sel
    );
        logic [cpu_params_pkg::XLEN-1:0] value;
        if (tag == '0) begin
            value = '0;
        end else begin
            value = regs[tag];
        end
        for (int k = 0; k < cpu_params_pkg::CDB_WIDTH; k++) begin
            if (sel[k]) begin
                value = cdb[k].rd_value;
            end
        end
        return value;
    endfunction

    always_comb begin
        rs.rs1_value = read_port(rs.rs1_phy, rs.bypass.rs1_bypass_en);
        rs.rs2_value = read_port(rs.rs2_phy, rs.bypass.rs2_bypass_en);
    end

    // two lanes writing the same register in one cycle
    always_comb begin
        tag_clash = 1'b0;
        for (int i = 0; i < cpu_params_pkg::CDB_WIDTH; i++) begin
            for (int j = i + 1; j < cpu_params_pkg::CDB_WIDTH; j++) begin
                if (lane_wr[i] && lane_wr[j] && (cdb[i].rd_phy == cdb[j].rd_phy)) begin
                    tag_clash = 1'b1;
                end
            end
        end
    end

    lane_tags_unique_a: assert property (
        @(posedge clk) !$isunknown(lane_wr) |-> !tag_clash
    ) else $error("prf: two CDB lanes write the same register");

    bypass_sel_onehot_a: assert property (
        @(posedge clk) !$isunknown(rs.bypass) |->
            $onehot0(rs.bypass.rs1_bypass_en) && $onehot0(rs.bypass.rs2_bypass_en)
    ) else $error("prf: multi-hot bypass select on read port");

endmodule

// File: src/prf_types_pkg.sv
package prf_types_pkg;

    // physical register tag
    typedef logic [cpu_params_pkg::PRF_IDX_W-1:0] phy_idx_t;

    // integer operations where SLT compares signed
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // one result bus lane
    typedef struct packed {
        logic                            valid;
        phy_idx_t                        rd_phy;
        logic [cpu_params_pkg::XLEN-1:0] rd_value;
    } cdb_t;

    // one-hot lane select per source where all zero reads the array
    typedef struct packed {
        logic [cpu_params_pkg::CDB_WIDTH-1:0] rs1_bypass_en;
        logic [cpu_params_pkg::CDB_WIDTH-1:0] rs2_bypass_en;
    } bypass_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        phy_idx_t rd_phy;
    } alu_req_t;

endpackage

// File: src/rs_prf_if.sv
`timescale 1ns/1ps

interface rs_prf_if;

    // source tags of the instruction held in the issue stage
    prf_types_pkg::phy_idx_t         rs1_phy;
    prf_types_pkg::phy_idx_t         rs2_phy;

    // lane choice per source
    prf_types_pkg::bypass_t          bypass;

    // operands valid in the same cycle as the tags
    logic [cpu_params_pkg::XLEN-1:0] rs1_value;
    logic [cpu_params_pkg::XLEN-1:0] rs2_value;

    modport rs (
        output rs1_phy,
        output rs2_phy,
        output bypass
    );

    modport prf (
        input  rs1_phy,
        input  rs2_phy,
        input  bypass,
        output rs1_value,
        output rs2_value
    );

    modport alu (
        input  rs1_value,
        input  rs2_value
    );

endinterface
